/* hdl/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes in inst[6:0]
`define RV_OP_RTYPE  7'b0110011  // Register-register ALU
`define RV_OP_ITYPE  7'b0010011  // Register-immediate ALU
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_SYSTEM 7'b1110011  // ECALL lives here

// funct3 values in inst[14:12]
`define RV_F3_ADD  3'b000  // Also SUB and ADDI
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101  // SRL or SRA by funct7
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111
`define RV_F3_LW   3'b010  // Word load
`define RV_F3_SW   3'b010  // Word store

// funct7 values in inst[31:25]
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000  // Selects SUB and SRA

`define MEM_WORDS 256  // Depth of the shared memory
`define N_REQ     3    // Fetch, data and host

`endif

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // One data or instruction word
    typedef logic [31:0] word_t;

    // Word address into the 256 word memory
    typedef logic [7:0] addr_t;

    typedef logic [4:0] reg_idx_t;  // Selects x0 to x31

    // Requester number (fetch 0, data 1, host 2)
    typedef logic [1:0] req_id_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,        // Out of reset until run
        FETCH,       // Instruction request held until gnt
        FETCH_WAIT,  // Instruction word comes back
        EXEC,        // Decode and ALU, ALU results written here
        MEM,         // Data request held until gnt
        MEM_WAIT,    // Load data comes back and is written
        HALT         // Parked after ECALL
    } core_state_t;

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t         rd1,
    output rv_pkg::word_t         rd2,
    input  wire logic             we,
    input  wire rv_pkg::reg_idx_t wr,
    input  wire rv_pkg::word_t    wd
);
    import rv_pkg::*;

    word_t regs [32];  // Entry 0 never written

    // Asynchronous reads
    // x0 reads as zero regardless of array contents
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;  // Whole file cleared
            end
        end else if (we && (wr != '0)) begin  // Writes to x0 dropped
            regs[wr] <= wd;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_alu (
    input  wire rv_pkg::word_t a,
    input  wire rv_pkg::word_t b,
    input  wire logic [3:0]    op,   // {funct7[5], funct3}
    output rv_pkg::word_t      y
);
    import rv_pkg::*;

    logic [4:0] shamt;  // Low five bits of b only
    logic       alt;    // SUB or SRA
    word_t      sra_y;

    assign shamt = b[4:0];
    assign alt   = op[3];

    // Kept on its own so the shift stays signed
    assign sra_y = $signed(a) >>> shamt;

    always_comb begin
        case (op[2:0])
            `RV_F3_ADD: begin
                y = alt ? (a - b) : (a + b);
            end
            `RV_F3_SLL: begin
                y = a << shamt;
            end
            `RV_F3_SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};  // Signed compare
            end
            `RV_F3_SLTU: begin
                y = {31'b0, a < b};
            end
            `RV_F3_XOR: begin
                y = a ^ b;
            end
            `RV_F3_SR: begin
                y = alt ? sra_y : (a >> shamt);  // Arithmetic or logical
            end
            `RV_F3_OR: begin
                y = a | b;
            end
            `RV_F3_AND: begin
                y = a & b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t inst,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    output rv_pkg::reg_idx_t   rd,
    output rv_pkg::word_t      imm,
    output logic [3:0]         alu_op,
    output logic               use_imm,
    output logic               is_alu,
    output logic               is_load,
    output logic               is_store,
    output logic               is_halt
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    logic       sel_s;  // Store immediate layout

    // Fixed field positions
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // Sign-extended immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm   = sel_s ? imm_s : imm_i;

    // Whatever is not recognized stops the core
    assign is_halt = !(is_alu || is_load || is_store);

    always_comb begin
        alu_op   = {1'b0, `RV_F3_ADD};  // Address adds by default
        use_imm  = 1'b0;
        is_alu   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        sel_s    = 1'b0;
        case (opcode)
            `RV_OP_RTYPE: begin
                if ((funct7 == `RV_F7_BASE) ||
                    ((funct7 == `RV_F7_ALT) &&
                     ((funct3 == `RV_F3_ADD) || (funct3 == `RV_F3_SR)))) begin
                    is_alu = 1'b1;
                    alu_op = {funct7[5], funct3};
                end
            end
            `RV_OP_ITYPE: begin
                use_imm = 1'b1;
                if (funct3 == `RV_F3_ADD) begin
                    is_alu = 1'b1;  // ADDI
                end else if ((funct3 == `RV_F3_SLL) && (funct7 == `RV_F7_BASE)) begin
                    is_alu = 1'b1;
                    alu_op = {1'b0, funct3};
                end else if ((funct3 == `RV_F3_SR) &&
                             ((funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT))) begin
                    is_alu = 1'b1;  // SRLI or SRAI
                    alu_op = {funct7[5], funct3};
                end
            end
            `RV_OP_LOAD: begin
                use_imm = 1'b1;
                is_load = (funct3 == `RV_F3_LW);
            end
            `RV_OP_STORE: begin
                use_imm  = 1'b1;
                sel_s    = 1'b1;
                is_store = (funct3 == `RV_F3_SW);
            end
            `RV_OP_SYSTEM: begin
                use_imm = 1'b0;  // ECALL ends up in is_halt
            end
            default: begin
                use_imm = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_mem_arbiter.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_mem_arbiter (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic [`N_REQ-1:0] req,
    input  wire logic [`N_REQ-1:0] we,
    input  wire rv_pkg::addr_t     addr0,
    input  wire rv_pkg::addr_t     addr1,
    input  wire rv_pkg::addr_t     addr2,
    input  wire rv_pkg::word_t     wdata0,
    input  wire rv_pkg::word_t     wdata1,
    input  wire rv_pkg::word_t     wdata2,
    output logic [`N_REQ-1:0]      gnt,
    output logic [`N_REQ-1:0]      rvalid,
    output logic                   mem_en,
    output logic                   mem_we,
    output rv_pkg::addr_t          mem_addr,
    output rv_pkg::word_t          mem_wdata
);
    import rv_pkg::*;

    req_id_t last_id;  // Most recent grant
    req_id_t cand;
    req_id_t sel;
    logic    found;
    logic    rd_pend;  // Read granted last cycle
    req_id_t rd_id;    // Who gets the read data
    addr_t   addr_arr  [`N_REQ];
    word_t   wdata_arr [`N_REQ];

    assign addr_arr[0]  = addr0;
    assign addr_arr[1]  = addr1;
    assign addr_arr[2]  = addr2;
    assign wdata_arr[0] = wdata0;
    assign wdata_arr[1] = wdata1;
    assign wdata_arr[2] = wdata2;

    // Search from the one after the last winner
    always_comb begin
        found = 1'b0;
        sel   = last_id;
        cand  = '0;
        for (int i = 1; i <= `N_REQ; i++) begin
            cand = req_id_t'((last_id + i) % `N_REQ);
            if (!found && req[cand]) begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    assign gnt       = found ? (`N_REQ'(1) << sel) : '0;  // One-hot or idle
    assign mem_en    = found;
    assign mem_we    = found & we[sel];
    assign mem_addr  = addr_arr[sel];
    assign mem_wdata = wdata_arr[sel];
    assign rvalid    = rd_pend ? (`N_REQ'(1) << rd_id) : '0;  // Follows memory latency

    always_ff @(posedge CLK) begin
        if (RST) begin
            last_id <= req_id_t'(`N_REQ - 1);  // Fetch first after reset
            rd_pend <= 1'b0;
            rd_id   <= '0;
        end else begin
            rd_pend <= found & ~we[sel];
            if (found) begin
                last_id <= sel;
            end
            if (found && !we[sel]) begin
                rd_id <= sel;  // Only reads return data
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_unified_mem.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_unified_mem (
    input  wire logic          CLK,
    input  wire logic          en,     // Access this cycle
    input  wire logic          we,     // Write when set, read otherwise
    input  wire rv_pkg::addr_t addr,
    input  wire rv_pkg::word_t wdata,
    output rv_pkg::word_t      rdata
);
    import rv_pkg::*;

    // Program and data share this array
    word_t mem [`MEM_WORDS];

    // Single port
    // Read data lands one cycle after the enabled read
    // rdata holds its value between reads
    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_ctrl (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic             run,
    output logic                  f_req,
    input  wire logic             f_gnt,
    input  wire logic             f_rvalid,
    output rv_pkg::addr_t         f_addr,
    output logic                  d_req,
    output logic                  d_we,
    input  wire logic             d_gnt,
    input  wire logic             d_rvalid,
    output rv_pkg::addr_t         d_addr,
    output rv_pkg::word_t         d_wdata,
    input  wire rv_pkg::word_t    rdata,
    input  wire rv_pkg::reg_idx_t rd,
    input  wire logic             is_alu,
    input  wire logic             is_load,
    input  wire logic             is_store,
    input  wire logic             is_halt,
    input  wire rv_pkg::word_t    alu_y,
    input  wire rv_pkg::word_t    rs2_val,  // Store data from the register file
    output rv_pkg::word_t         inst,
    output logic                  rf_we,
    output rv_pkg::reg_idx_t      rf_wr,
    output rv_pkg::word_t         rf_wd,
    output logic                  halted
);
    import rv_pkg::*;

    core_state_t state;
    word_t       pc;       // Byte address
    word_t       pc_next;

    assign pc_next = pc + 32'd4;

    // Requests are held for the whole state
    assign f_req  = (state == FETCH);
    assign f_addr = pc[9:2];
    assign d_req  = (state == MEM);
    assign d_we   = (state == MEM) && is_store;

    // ALU results in EXEC and load data in MEM_WAIT
    assign rf_we  = ((state == EXEC) && is_alu) || ((state == MEM_WAIT) && d_rvalid);
    assign rf_wr  = rd;
    assign rf_wd  = (state == MEM_WAIT) ? rdata : alu_y;
    assign halted = (state == HALT);  // Cycle after ECALL's EXEC

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        pc    <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (f_gnt) state <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (f_rvalid) state <= EXEC;
                end
                EXEC: begin
                    if (is_halt) begin
                        state <= HALT;  // PC stays on the ECALL
                    end else if (is_load || is_store) begin
                        state <= MEM;
                    end else begin
                        pc    <= pc_next;
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (d_gnt && is_store) begin
                        pc    <= pc_next;  // Store done at grant
                        state <= FETCH;
                    end else if (d_gnt) begin
                        state <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (d_rvalid) begin
                        pc    <= pc_next;
                        state <= FETCH;
                    end
                end
                HALT: state <= HALT;  // Only reset leaves
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction and data access fields
    always_ff @(posedge CLK) begin
        if ((state == FETCH_WAIT) && f_rvalid) begin
            inst <= rdata;
        end
        if (state == EXEC) begin
            d_addr  <= alu_y[9:2];  // Word part of the ALU sum
            d_wdata <= rs2_val;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_cpu_top.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_cpu_top (
    input  wire logic          CLK,
    input  wire logic          RST,
    input  wire logic          run,
    input  wire logic          host_req,
    input  wire logic          host_we,
    input  wire rv_pkg::addr_t host_addr,
    input  wire rv_pkg::word_t host_wdata,
    output logic               host_gnt,
    output logic               host_rvalid,
    output rv_pkg::word_t      host_rdata,
    output logic               halted
);
    import rv_pkg::*;

    logic              f_req, f_gnt, f_rvalid;
    addr_t             f_addr;
    logic              d_req, d_we, d_gnt, d_rvalid;
    addr_t             d_addr;
    word_t             d_wdata;
    word_t             inst;
    reg_idx_t          rs1, rs2, rd;
    word_t             imm;
    logic [3:0]        alu_op;
    logic              use_imm, is_alu, is_load, is_store, is_halt;
    word_t             rd1, rd2, alu_b, alu_y;
    logic              rf_we;
    reg_idx_t          rf_wr;
    word_t             rf_wd;
    logic [`N_REQ-1:0] arb_gnt, arb_rvalid;
    logic              mem_en, mem_we;
    addr_t             mem_addr;
    word_t             mem_wdata, mem_rdata;

    // Port 0 fetch, 1 data, 2 host
    assign f_gnt       = arb_gnt[0];
    assign d_gnt       = arb_gnt[1];
    assign host_gnt    = arb_gnt[2];
    assign f_rvalid    = arb_rvalid[0];
    assign d_rvalid    = arb_rvalid[1];
    assign host_rvalid = arb_rvalid[2];
    assign host_rdata  = mem_rdata;  // Shared read bus

    assign alu_b = use_imm ? imm : rd2;  // Immediate or rs2

    rv_core_ctrl rv_core_ctrl_inst (
        .CLK(CLK), .RST(RST), .run(run),
        .f_req(f_req), .f_gnt(f_gnt), .f_rvalid(f_rvalid), .f_addr(f_addr),
        .d_req(d_req), .d_we(d_we), .d_gnt(d_gnt), .d_rvalid(d_rvalid),
        .d_addr(d_addr), .d_wdata(d_wdata), .rdata(mem_rdata),
        .rd(rd), .is_alu(is_alu), .is_load(is_load), .is_store(is_store),
        .is_halt(is_halt), .alu_y(alu_y), .rs2_val(rd2), .inst(inst),
        .rf_we(rf_we), .rf_wr(rf_wr), .rf_wd(rf_wd), .halted(halted)
    );

    rv_regfile rv_regfile_inst (
        .CLK(CLK), .RST(RST), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .we(rf_we), .wr(rf_wr), .wd(rf_wd)
    );

    rv_decode rv_decode_inst (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .is_alu(is_alu), .is_load(is_load),
        .is_store(is_store), .is_halt(is_halt)
    );

    rv_alu rv_alu_inst (.a(rd1), .b(alu_b), .op(alu_op), .y(alu_y));

    rv_mem_arbiter rv_mem_arbiter_inst (
        .CLK(CLK), .RST(RST),
        .req({host_req, d_req, f_req}), .we({host_we, d_we, 1'b0}),
        .addr0(f_addr), .addr1(d_addr), .addr2(host_addr),
        .wdata0('0), .wdata1(d_wdata), .wdata2(host_wdata),
        .gnt(arb_gnt), .rvalid(arb_rvalid), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    rv_unified_mem rv_unified_mem_inst (
        .CLK(CLK), .en(mem_en), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/rv_cpu_assert.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_cpu_assert (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic [`N_REQ-1:0] req,
    input  wire logic [`N_REQ-1:0] we,
    input  wire logic [`N_REQ-1:0] gnt,
    input  wire logic [`N_REQ-1:0] rvalid,
    input  wire rv_pkg::addr_t     addr0,
    input  wire rv_pkg::addr_t     addr1,
    input  wire rv_pkg::addr_t     addr2,
    input  wire rv_pkg::word_t     wdata0,
    input  wire rv_pkg::word_t     wdata1,
    input  wire rv_pkg::word_t     wdata2,
    input  wire logic              halted
);
    import rv_pkg::*;

    addr_t addr_v  [`N_REQ];
    word_t wdata_v [`N_REQ];
    int    err_count = 0;  // Failed assertions so far

    assign addr_v[0]  = addr0;
    assign addr_v[1]  = addr1;
    assign addr_v[2]  = addr2;
    assign wdata_v[0] = wdata0;
    assign wdata_v[1] = wdata1;
    assign wdata_v[2] = wdata2;

    // Single winner per cycle
    a_one_gnt: assert property (@(posedge CLK) disable iff (RST) $onehot0(gnt))
        else begin
            $error("more than one grant in one cycle");
            err_count++;
        end

    // Halt is sticky until reset
    a_halt_sticky: assert property (@(posedge CLK) disable iff (RST) halted |=> halted)
        else begin
            $error("halted fell without a reset");
            err_count++;
        end

    for (genvar i = 0; i < `N_REQ; i++) begin : g_req
        a_read_rvalid: assert property (@(posedge CLK) disable iff (RST)
            (gnt[i] && !we[i]) |=> rvalid[i])
            else begin
                $error("read grant on port %0d not followed by rvalid", i);
                err_count++;
            end
        a_rvalid_src: assert property (@(posedge CLK) disable iff (RST)
            rvalid[i] |-> $past(gnt[i] && !we[i]))
            else begin
                $error("rvalid on port %0d without a read grant", i);
                err_count++;
            end
        // Waiting requester keeps its fields
        a_req_hold: assert property (@(posedge CLK) disable iff (RST)
            (req[i] && !gnt[i]) |=> (req[i] && $stable(we[i]) &&
                                     $stable(addr_v[i]) && $stable(wdata_v[i])))
            else begin
                $error("request on port %0d changed before its grant", i);
                err_count++;
            end
    end

endmodule

// Arbiter view, all three ports
bind rv_mem_arbiter rv_cpu_assert arb_chk_inst (
    .CLK(CLK), .RST(RST), .req(req), .we(we), .gnt(gnt), .rvalid(rvalid),
    .addr0(addr0), .addr1(addr1), .addr2(addr2),
    .wdata0(wdata0), .wdata1(wdata1), .wdata2(wdata2), .halted(1'b0)
);

// Controller view, host slot tied off
bind rv_core_ctrl rv_cpu_assert ctrl_chk_inst (
    .CLK(CLK), .RST(RST),
    .req({1'b0, d_req, f_req}), .we({1'b0, d_we, 1'b0}),
    .gnt({1'b0, d_gnt, f_gnt}), .rvalid({1'b0, d_rvalid, f_rvalid}),
    .addr0(f_addr), .addr1(d_addr), .addr2('0),
    .wdata0('0), .wdata1(d_wdata), .wdata2('0), .halted(halted)
);

`default_nettype wire

/* dv/rv_cpu_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"
`default_nettype none

module rv_cpu_tb;
    import rv_pkg::*;

    localparam int GNT_TIMEOUT = 100;   // Cycles per host grant
    localparam int RUN_TIMEOUT = 5000;  // Loop passes until halted
    localparam int OPND_WORD   = 128;   // Random operands
    localparam int RES_BYTE    = 640;   // Result area, word 160 up
    localparam int SCAN_LIMIT  = 160;   // Host reads during run stay below results

    // R-type sequence, SUB and SRA at 1 and 7
    localparam logic [2:0] R_F3 [10] = '{`RV_F3_ADD, `RV_F3_ADD, `RV_F3_SLL, `RV_F3_SLT,
        `RV_F3_SLTU, `RV_F3_XOR, `RV_F3_SR, `RV_F3_SR, `RV_F3_OR, `RV_F3_AND};
    localparam logic [9:0] R_ALT = 10'b0010000010;

    logic  CLK;
    logic  RST;
    logic  run;
    logic  host_req;
    logic  host_we;
    addr_t host_addr;
    word_t host_wdata;
    logic  host_gnt;
    logic  host_rvalid;
    word_t host_rdata;
    logic  halted;

    int    seed;
    int    errors;
    int    code_w;  // Next free code word
    int    res_b;   // Next result byte address
    word_t init_img [`MEM_WORDS];
    word_t exp_img  [`MEM_WORDS];

    rv_cpu_top rv_cpu_top_inst (
        .CLK(CLK), .RST(RST), .run(run),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_gnt(host_gnt), .host_rvalid(host_rvalid),
        .host_rdata(host_rdata), .halted(halted)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic fail_stop(input string msg);
        errors++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("mismatch at %0t ns: %s got %08h expected %08h",
                                $time, what, got, exp));
        end
    endtask

    // Failures flagged by the bound checkers
    function automatic int assert_fails();
        return rv_cpu_top_inst.rv_mem_arbiter_inst.arb_chk_inst.err_count +
               rv_cpu_top_inst.rv_core_ctrl_inst.ctrl_chk_inst.err_count;
    endfunction

    always @(negedge CLK) begin
        if (assert_fails() != 0) begin
            fail_stop($sformatf("assertion failure in a bound checker at %0t ns", $time));
        end
    end

    // Instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rd,
                                    input reg_idx_t rs1, input reg_idx_t rs2,
                                    input logic [2:0] f3);
        return {f7, rs2, rs1, f3, rd, `RV_OP_RTYPE};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rd,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, `RV_F3_SW, imm[4:0], `RV_OP_STORE};
    endfunction

    // RV32I operation semantics
    function automatic word_t isa_op(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        word_t sra_v;
        sra_v = $signed(a) >>> b[4:0];
        case (f3)
            `RV_F3_ADD:  return alt ? (a - b) : (a + b);
            `RV_F3_SLL:  return a << b[4:0];
            `RV_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SR:   return alt ? sra_v : (a >> b[4:0]);
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    // ISA model over its own registers and memory copy
    function automatic void ref_run(input word_t init [`MEM_WORDS],
                                    output word_t img [`MEM_WORDS]);
        word_t      x [32];
        word_t      pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       stop;
        int         steps;
        for (int i = 0; i < `MEM_WORDS; i++) img[i] = init[i];
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc    = '0;
        stop  = 1'b0;
        steps = 0;
        while (!stop && (steps < 1000)) begin
            ins   = img[pc[9:2]];
            opc   = ins[6:0];
            f3    = ins[14:12];
            f7    = ins[31:25];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            if ((opc == `RV_OP_RTYPE) && ((f7 == `RV_F7_BASE) || ((f7 == `RV_F7_ALT) &&
                ((f3 == `RV_F3_ADD) || (f3 == `RV_F3_SR))))) begin
                x[ins[11:7]] = isa_op(f3, f7[5], a, b);
            end else if ((opc == `RV_OP_ITYPE) && ((f3 == `RV_F3_ADD) ||
                         ((f3 == `RV_F3_SLL) && (f7 == `RV_F7_BASE)) ||
                         ((f3 == `RV_F3_SR) && ((f7 == `RV_F7_BASE) || (f7 == `RV_F7_ALT))))) begin
                x[ins[11:7]] = isa_op(f3, (f3 == `RV_F3_SR) && f7[5], a, imm_i);
            end else if ((opc == `RV_OP_LOAD) && (f3 == `RV_F3_LW)) begin
                imm_i        = a + imm_i;  // Effective byte address
                x[ins[11:7]] = img[imm_i[9:2]];
            end else if ((opc == `RV_OP_STORE) && (f3 == `RV_F3_SW)) begin
                imm_s          = a + imm_s;
                img[imm_s[9:2]] = b;
            end else begin
                stop = 1'b1;  // ECALL or anything unsupported
            end
            x[0] = '0;
            if (!stop) pc = pc + 32'd4;
            steps++;
        end
    endfunction

    task automatic emit(input word_t w);
        init_img[code_w] = w;
        code_w++;
    endtask

    task automatic store_reg(input reg_idx_t r);
        emit(enc_s(12'(res_b), r, 5'd0));
        res_b += 4;
    endtask

    task automatic build_program();
        code_w = 0;
        res_b  = RES_BYTE;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            init_img[i] = {8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};  // Address tagged fill
        end
        for (int i = 0; i < 4; i++) init_img[OPND_WORD + i] = $random(seed);
        init_img[OPND_WORD + 1][31] = 1'b1;  // Force one negative operand
        for (int i = 0; i < 3; i++) begin  // x1..x3 from memory
            emit(enc_i(12'(OPND_WORD * 4 + 4 * i), reg_idx_t'(i + 1), 5'd0,
                       `RV_F3_LW, `RV_OP_LOAD));
        end
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 10; k++) begin
                emit(enc_r(R_ALT[k] ? `RV_F7_ALT : `RV_F7_BASE, 5'd4,
                           reg_idx_t'(p + 1), reg_idx_t'(p + 2), R_F3[k]));
                store_reg(5'd4);
            end
        end
        emit(enc_i(12'hfff, 5'd5, 5'd1, `RV_F3_ADD, `RV_OP_ITYPE));  // -1
        emit(enc_i(12'h7ff, 5'd6, 5'd2, `RV_F3_ADD, `RV_OP_ITYPE));  // Largest positive
        emit(enc_i(12'h800, 5'd7, 5'd3, `RV_F3_ADD, `RV_OP_ITYPE));  // Most negative
        emit(enc_i(12'h01f, 5'd8, 5'd1, `RV_F3_SLL, `RV_OP_ITYPE));
        emit(enc_i(12'h011, 5'd9, 5'd2, `RV_F3_SR, `RV_OP_ITYPE));
        emit(enc_i({`RV_F7_ALT, 5'd7}, 5'd10, 5'd2, `RV_F3_SR, `RV_OP_ITYPE));
        emit(enc_i({`RV_F7_ALT, 5'd0}, 5'd11, 5'd1, `RV_F3_SR, `RV_OP_ITYPE));
        for (int r = 5; r <= 11; r++) store_reg(reg_idx_t'(r));
        emit(enc_i(12'd123, 5'd0, 5'd1, `RV_F3_ADD, `RV_OP_ITYPE));  // x0 targets
        emit(enc_r(`RV_F7_BASE, 5'd0, 5'd1, 5'd2, `RV_F3_ADD));
        store_reg(5'd0);
        // Loaded values used right away
        emit(enc_i(12'(OPND_WORD * 4 + 12), 5'd12, 5'd0, `RV_F3_LW, `RV_OP_LOAD));
        emit(enc_r(`RV_F7_BASE, 5'd13, 5'd12, 5'd12, `RV_F3_ADD));
        store_reg(5'd13);
        emit(enc_i(12'(RES_BYTE), 5'd14, 5'd0, `RV_F3_LW, `RV_OP_LOAD));
        emit(enc_r(`RV_F7_ALT, 5'd15, 5'd14, 5'd12, `RV_F3_ADD));
        store_reg(5'd15);
        emit({25'b0, `RV_OP_SYSTEM});     // ECALL
        emit(enc_s(12'd1000, 5'd1, 5'd0));  // Must never execute
    endtask

    task automatic wait_host_gnt(input string what);
        int n;
        n = 0;
        @(negedge CLK);
        while (!host_gnt) begin
            n++;
            if (n > GNT_TIMEOUT) begin
                fail_stop($sformatf("timeout at %0t ns: host %s never granted", $time, what));
            end
            @(negedge CLK);
        end
    endtask

    task automatic host_write(input addr_t a, input word_t d);
        @(posedge CLK);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= a;
        host_wdata <= d;
        wait_host_gnt("write");
        @(posedge CLK);  // Grant edge
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_read(input addr_t a, output word_t d);
        @(posedge CLK);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= a;
        wait_host_gnt("read");
        @(posedge CLK);
        host_req <= 1'b0;
        @(negedge CLK);  // One cycle after gnt
        check("host_rvalid after read gnt", {31'b0, host_rvalid}, 32'd1);
        d = host_rdata;
    endtask

    task automatic reset_dut();
        @(posedge CLK);
        RST <= 1'b1;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        @(negedge CLK);
        check("halted after reset", {31'b0, halted}, 32'd0);
        check("host_gnt after reset", {31'b0, host_gnt}, 32'd0);
        check("host_rvalid after reset", {31'b0, host_rvalid}, 32'd0);
    endtask

    task automatic compare_memory(input word_t img [`MEM_WORDS], input string tag);
        word_t d;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            host_read(addr_t'(i), d);
            check($sformatf("%s word %0d", tag, i), d, img[i]);
        end
    endtask

    // Optional host reads of static words while the core runs
    task automatic wait_halted(input logic contend);
        int    n;
        addr_t a;
        word_t d;
        n = 0;
        @(negedge CLK);
        while (!halted) begin
            n++;
            if (n > RUN_TIMEOUT) begin
                fail_stop($sformatf("timeout at %0t ns: core never halted", $time));
            end
            if (contend && (($random(seed) & 1) == 0)) begin
                a = addr_t'($random(seed)) % 8'(SCAN_LIMIT);
                host_read(a, d);
                check($sformatf("host read of word %0d during run", a), d, init_img[a]);
            end else begin
                @(negedge CLK);
            end
        end
    endtask

    initial begin
        RST        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'hf030;
        errors     = 0;
        build_program();
        ref_run(init_img, exp_img);
        // Quiet run first, then the same program under host contention
        for (int pass = 0; pass < 2; pass++) begin
            reset_dut();
            for (int i = 0; i < `MEM_WORDS; i++) host_write(addr_t'(i), init_img[i]);
            compare_memory(init_img, "loaded");
            @(posedge CLK);
            run <= 1'b1;
            @(posedge CLK);
            run <= 1'b0;
            wait_halted(pass == 1);
            repeat (20) begin
                @(negedge CLK);
                check("halted held after ECALL", {31'b0, halted}, 32'd1);
            end
            compare_memory(exp_img, (pass == 1) ? "contended result" : "result");
        end
        if ((errors == 0) && (assert_fails() == 0)) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_decode.sv
hdl/rv_mem_arbiter.sv
hdl/rv_unified_mem.sv
hdl/rv_core_ctrl.sv
hdl/rv_cpu_top.sv
dv/rv_cpu_assert.sv
dv/rv_cpu_tb.sv
